// File: back_loop_detect.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module back_loop_detect
   import loop_pkg::*;
(
   input  logic [`BUS_W-1:0] inst_bus,
   output slot_mask_t        bck_lp_bus
);

   inst_t                   slot_inst [`FETCH_WIDTH];
   logic [`OPC_W-1:0]       slot_opc  [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0] slot_neg;   // offset sign per slot, slot 0 at msb

   // split bundle into slots, slot 0 from the top word
   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         slot_inst[i] = inst_bus[(`FETCH_WIDTH-1-i)*`INST_W +: `INST_W];
         slot_opc[i]  = slot_inst[i][`INST_W-1 -: `OPC_W];
         slot_neg[`FETCH_WIDTH-1-i] = slot_inst[i][`INST_W-`OPC_W-1];
      end
   end

   // every backward branch is taken as a loop close
   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         bck_lp_bus[`FETCH_WIDTH-1-i] = (slot_opc[i] == `BR_OPC) &&
                                        slot_neg[`FETCH_WIDTH-1-i];
      end
   end

endmodule

// File: fetch_pc_gen.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module fetch_pc_gen
   import loop_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              redirect,
   input  pc_t               redirect_pc,
   input  logic              stll_ftch,
   output pc_t               fetch_pc,
   output logic [`BUS_W-1:0] pc_bus
);

   // redirect beats stall, stall beats sequential advance
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetch_pc <= `RESET_PC;
      end else if (redirect) begin
         fetch_pc <= redirect_pc;
      end else if (stll_ftch) begin
         fetch_pc <= fetch_pc;   // loop buffer full
      end else begin
         fetch_pc <= fetch_pc + pc_t'(`FETCH_WIDTH);
      end
   end

   // four sequential slot addresses, slot 0 in the top word
   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         pc_bus[(`FETCH_WIDTH-1-i)*`PC_W +: `PC_W] = fetch_pc + pc_t'(i);
      end
   end

endmodule

// File: files.f
+incdir+.
loop_pkg.sv
fetch_pc_gen.sv
back_loop_detect.sv
loop_addr_table.sv
loop_fetch_top.sv
loop_fetch_sva.sv
tb_loop_fetch.sv

// File: loop_addr_table.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_addr_table
   import loop_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  slot_mask_t        bck_lp_bus,
   input  logic [`BUS_W-1:0] pc_bus,
   input  logic              mis_pred,
   output lbd_state_e        lbd_state,
   output logic              loop_strt,
   output slot_mask_t        inst_valid,
   output logic              fnsh_unrll,
   output logic              stll_ftch
);

   // entry word is {start, fall-through, length, unroll limit}
   localparam int FT_LSB = 2 * `CNT_W;
   localparam int ST_LSB = FT_LSB + `PC_W;
   localparam int ENT_W  = ST_LSB + `PC_W;
   localparam int PTR_W  = $clog2(`LAT_ENTRIES);
   localparam slot_mask_t ALL_SLOTS = '1;

   lbd_state_e              state, nxt_state;
   pc_t                     slot_pc [`FETCH_WIDTH];
   slot_mask_t              end_train, end_disp;   // slot holds the loop-end pc
   lat_cnt_t                train_cnt, disp_cnt;

   pc_t                     ft_train, start_addr, ft_disp;
   lat_cnt_t                body_len, max_unroll_train;
   lat_cnt_t                unroll_cnt, fill_cnt;
   logic                    ft_train_en, write_en, write2lat;

   logic [ENT_W-1:0]        lat_mem [`LAT_ENTRIES];
   logic [`LAT_ENTRIES-1:0] lat_vld;
   logic [PTR_W-1:0]        lat_ptr;
   logic [`LAT_ENTRIES-1:0] ent_hit;
   pc_t                     hit_ft;
   lat_cnt_t                hit_unroll;

   // k+1 for the first flagged slot k or full width when none
   function automatic lat_cnt_t lead_cnt(slot_mask_t m);
      lat_cnt_t n;
      n = lat_cnt_t'(`FETCH_WIDTH);
      for (int k = `FETCH_WIDTH - 1; k >= 0; k--) begin
         if (m[`FETCH_WIDTH-1-k]) n = lat_cnt_t'(k + 1);
      end
      return n;
   endfunction

   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         slot_pc[i] = pc_bus[(`FETCH_WIDTH-1-i)*`PC_W +: `PC_W];
         end_train[`FETCH_WIDTH-1-i] = (slot_pc[i] == ft_train - 1'b1);
         end_disp[`FETCH_WIDTH-1-i]  = (slot_pc[i] == ft_disp - 1'b1);
      end
   end

   assign train_cnt = lead_cnt(end_train);
   assign disp_cnt  = lead_cnt(end_disp);

   assign max_unroll_train = (body_len != '0 && body_len <= lat_cnt_t'(`MAX_LOOP_BODY)) ?
                             lat_cnt_t'(1) : lat_cnt_t'(0);

   // start match against the table; the entry being written is compared
   // with the training registers since its word is not stored yet
   always_comb begin
      ent_hit    = '0;
      hit_ft     = ft_train;
      hit_unroll = max_unroll_train;
      for (int i = `LAT_ENTRIES - 1; i >= 0; i--) begin   // lowest index wins
         if (write2lat && lat_ptr == PTR_W'(i)) begin
            ent_hit[i] = (slot_pc[0] == start_addr);
            if (ent_hit[i]) begin
               hit_ft     = ft_train;
               hit_unroll = max_unroll_train;
            end
         end else begin
            ent_hit[i] = lat_vld[i] && (slot_pc[0] == lat_mem[i][ST_LSB +: `PC_W]);
            if (ent_hit[i]) begin
               hit_ft     = lat_mem[i][FT_LSB +: `PC_W];
               hit_unroll = lat_mem[i][`CNT_W-1:0];
            end
         end
      end
   end

   assign loop_strt = (state != LBD_DISPATCH) && (|ent_hit);

   always_comb begin
      nxt_state   = state;
      ft_train_en = 1'b0;
      write_en    = 1'b0;
      case (state)
         LBD_IDLE: begin
            if (loop_strt) begin
               nxt_state = LBD_DISPATCH;
            end else if (|bck_lp_bus) begin
               nxt_state   = LBD_TRAIN;
               ft_train_en = 1'b1;
            end
         end
         LBD_TRAIN: begin
            if (loop_strt) begin
               nxt_state = LBD_DISPATCH;   // known loop, drop training
            end else if (|end_train) begin
               nxt_state = LBD_IDLE;
               write_en  = 1'b1;
            end
         end
         LBD_DISPATCH: begin
            if (mis_pred) nxt_state = LBD_IDLE;
         end
         default: nxt_state = LBD_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= LBD_IDLE;
         write2lat <= 1'b0;
      end else begin
         state     <= nxt_state;
         write2lat <= write_en;   // table write one edge after training end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         body_len   <= '0;
         fill_cnt   <= '0;
         unroll_cnt <= '0;
      end else begin
         body_len <= (state == LBD_TRAIN) ? body_len + train_cnt : '0;
         fill_cnt <= (state == LBD_DISPATCH) ? fill_cnt + disp_cnt : '0;
         if (loop_strt) begin
            unroll_cnt <= hit_unroll;
         end else if (state == LBD_IDLE) begin
            unroll_cnt <= '0;
         end else if (state == LBD_DISPATCH && (|end_disp) && unroll_cnt != '0) begin
            unroll_cnt <= unroll_cnt - 1'b1;   // holds at zero
         end
      end
   end

   // training and dispatch addresses
   always_ff @(posedge clk) begin
      if (ft_train_en) ft_train <= lead_cnt(bck_lp_bus) - 1'b1 + slot_pc[0] + 1'b1;
      if (state == LBD_TRAIN && body_len == '0) start_addr <= slot_pc[0];
      if (loop_strt) ft_disp <= hit_ft;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lat_vld <= '0;
         lat_ptr <= '0;
      end else if (write2lat) begin
         lat_vld[lat_ptr] <= 1'b1;
         lat_ptr          <= lat_ptr + 1'b1;   // round robin
      end
   end

   always_ff @(posedge clk) begin
      if (write2lat) lat_mem[lat_ptr] <= {start_addr, ft_train, body_len, max_unroll_train};
   end

   assign lbd_state  = state;
   assign inst_valid = (state == LBD_DISPATCH) ? ~(ALL_SLOTS >> disp_cnt) : ALL_SLOTS;
   assign fnsh_unrll = (state == LBD_DISPATCH) && (unroll_cnt == '0);
   assign stll_ftch  = (state == LBD_DISPATCH) &&
                       (fill_cnt == lat_cnt_t'(`LOOP_BUF_DEPTH));

endmodule

// File: loop_consts.svh
`ifndef LOOP_CONSTS_SVH
`define LOOP_CONSTS_SVH

// fetch bundle geometry
`define FETCH_WIDTH     4
`define PC_W            16
`define INST_W          16
`define BUS_W           (`FETCH_WIDTH * `PC_W)

// instruction fields
`define OPC_W           4
`define BR_OPC          4'hB

`define RESET_PC        16'h0100

// loop table and loop buffer
`define LAT_ENTRIES     4
`define CNT_W           7
`define LOOP_BUF_DEPTH  64   // fill count that stalls fetch
`define MAX_LOOP_BODY   64   // longest body allowed to unroll

`endif

// File: loop_fetch_sva.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_fetch_sva
   import loop_pkg::*;
(
   input logic       clk,
   input logic       rst,
   input logic       redirect,
   input pc_t        redirect_pc,
   input logic       mis_pred,
   input pc_t        fetch_pc,
   input lbd_state_e lbd_state,
   input logic       loop_strt,
   input slot_mask_t inst_valid,
   input logic       fnsh_unrll,
   input logic       stll_ftch
);

   a_reset_outs: assert property (@(posedge clk)
      rst |-> (lbd_state == LBD_IDLE && !loop_strt && !fnsh_unrll && !stll_ftch &&
               inst_valid == 4'hF))
      else $error("outputs not at reset values");

   a_advance: assert property (@(posedge clk) disable iff (rst)
      (!redirect && !stll_ftch) |=> fetch_pc == $past(fetch_pc) + 16'd4)
      else $error("fetch_pc did not advance by four");

   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      (stll_ftch && !redirect) |=> fetch_pc == $past(fetch_pc))
      else $error("fetch_pc moved during a stall");

   a_redirect: assert property (@(posedge clk) disable iff (rst)
      redirect |=> fetch_pc == $past(redirect_pc))
      else $error("redirect not taken");

   a_stall_disp: assert property (@(posedge clk) disable iff (rst)
      stll_ftch |-> lbd_state == LBD_DISPATCH)
      else $error("stall outside dispatch");

   a_strt_disp: assert property (@(posedge clk) disable iff (rst)
      loop_strt |=> lbd_state == LBD_DISPATCH)
      else $error("loop start did not enter dispatch");

   a_mispred: assert property (@(posedge clk) disable iff (rst)
      (mis_pred && lbd_state == LBD_DISPATCH) |=> lbd_state == LBD_IDLE)
      else $error("mispredict did not return to idle");

   // slot mask is always a run of leading ones
   a_mask_form: assert property (@(posedge clk) disable iff (rst)
      inst_valid inside {4'h8, 4'hC, 4'hE, 4'hF})
      else $error("inst_valid not a leading-ones mask");

   a_mask_idle: assert property (@(posedge clk) disable iff (rst)
      lbd_state != LBD_DISPATCH |-> inst_valid == 4'hF)
      else $error("inst_valid masked outside dispatch");

   a_finish_hold: assert property (@(posedge clk) disable iff (rst)
      fnsh_unrll |=> (fnsh_unrll || lbd_state != LBD_DISPATCH))
      else $error("unroll finish dropped inside dispatch");

endmodule

bind loop_fetch_top loop_fetch_sva i_sva (
   .clk         (clk),
   .rst         (rst),
   .redirect    (redirect),
   .redirect_pc (redirect_pc),
   .mis_pred    (mis_pred),
   .fetch_pc    (fetch_pc),
   .lbd_state   (lbd_state),
   .loop_strt   (loop_strt),
   .inst_valid  (inst_valid),
   .fnsh_unrll  (fnsh_unrll),
   .stll_ftch   (stll_ftch)
);

// File: loop_fetch_top.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_fetch_top
   import loop_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [`BUS_W-1:0] inst_bus,
   input  logic              redirect,
   input  pc_t               redirect_pc,
   input  logic              mis_pred,
   output pc_t               fetch_pc,
   output lbd_state_e        lbd_state,
   output logic              loop_strt,
   output slot_mask_t        inst_valid,
   output logic              fnsh_unrll,
   output logic              stll_ftch
);

   logic [`BUS_W-1:0] pc_bus;       // slot pcs, slot 0 on top
   slot_mask_t        bck_lp_bus;

   fetch_pc_gen i_fetch_pc_gen (
      .clk         (clk),
      .rst         (rst),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .stll_ftch   (stll_ftch),
      .fetch_pc    (fetch_pc),
      .pc_bus      (pc_bus)
   );

   back_loop_detect i_back_loop_detect (
      .inst_bus   (inst_bus),
      .bck_lp_bus (bck_lp_bus)
   );

   loop_addr_table i_loop_addr_table (
      .clk        (clk),
      .rst        (rst),
      .bck_lp_bus (bck_lp_bus),
      .pc_bus     (pc_bus),
      .mis_pred   (mis_pred),
      .lbd_state  (lbd_state),
      .loop_strt  (loop_strt),
      .inst_valid (inst_valid),
      .fnsh_unrll (fnsh_unrll),
      .stll_ftch  (stll_ftch)
   );

endmodule

// File: loop_pkg.sv
`include "loop_consts.svh"

package loop_pkg;

   // instruction address, counted in instructions not bytes
   typedef logic [`PC_W-1:0] pc_t;

   // opcode in the top bits, signed branch offset below
   typedef logic [`INST_W-1:0] inst_t;

   // one bit per slot, slot 0 at the msb
   typedef logic [`FETCH_WIDTH-1:0] slot_mask_t;

   // body length, unroll count, buffer fill
   typedef logic [`CNT_W-1:0] lat_cnt_t;

   typedef enum logic [1:0] {
      LBD_IDLE     = 2'd0,
      LBD_TRAIN    = 2'd1,
      LBD_DISPATCH = 2'd2
   } lbd_state_e;

endpackage

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_loop_fetch -f files.f -o tb_loop_fetch > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/tb_loop_fetch > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
   exit 0
fi
exit 1

// File: tb_loop_fetch.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module tb_loop_fetch
   import loop_pkg::*;
();

   logic              clk;
   logic              rst;
   logic [`BUS_W-1:0] inst_bus;
   logic              redirect;
   pc_t               redirect_pc;
   logic              mis_pred;
   pc_t               fetch_pc;
   lbd_state_e        lbd_state;
   logic              loop_strt;
   slot_mask_t        inst_valid;
   logic              fnsh_unrll;
   logic              stll_ftch;

   int   errors;
   int   timeouts;
   logic trained;     // table holds the loop once training has ended
   logic dispatching; // dut expected in dispatch
   logic end_passed;  // loop-end bundle already seen in this dispatch
   pc_t  loop_end;    // address of the backward branch
   pc_t  loop_start;  // branch target
   int   body_off;

   loop_fetch_top i_dut (
      .clk         (clk),
      .rst         (rst),
      .inst_bus    (inst_bus),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .mis_pred    (mis_pred),
      .fetch_pc    (fetch_pc),
      .lbd_state   (lbd_state),
      .loop_strt   (loop_strt),
      .inst_valid  (inst_valid),
      .fnsh_unrll  (fnsh_unrll),
      .stll_ftch   (stll_ftch)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // program memory returns nops except at the one backward branch
   function automatic inst_t mem_word(pc_t pc);
      logic [11:0] off;
      off = 12'(-body_off);
      if (pc == loop_end) return {`BR_OPC, off};
      return 16'h0000;
   endfunction

   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         inst_bus[(`FETCH_WIDTH-1-i)*`INST_W +: `INST_W] = mem_word(fetch_pc + pc_t'(i));
      end
   end

   function automatic logic holds_end(pc_t pc);
      pc_t d;
      d = loop_end - pc;
      return d < pc_t'(`FETCH_WIDTH);
   endfunction

   // leading ones up to and including the slot with the loop end
   function automatic slot_mask_t expected_mask(pc_t pc);
      if (!dispatching || !holds_end(pc)) return 4'hF;
      case (loop_end - pc)
         16'd0:   return 4'h8;
         16'd1:   return 4'hC;
         16'd2:   return 4'hE;
         default: return 4'hF;
      endcase
   endfunction

   task automatic check_port(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_state(input lbd_state_e s, input int limit);
      int n;
      n = 0;
      while (lbd_state != s && n < limit) begin
         next_cycle();
         n++;
      end
      if (lbd_state != s) begin
         timeouts++;
         $display("timeout while waiting for state %s", s.name());
      end
   endtask

   task automatic wait_stall(input int limit);
      int n;
      n = 0;
      while (!stll_ftch && n < limit) begin
         next_cycle();
         n++;
      end
      if (!stll_ftch) begin
         timeouts++;
         $display("timeout while waiting for the fetch stall");
      end
   endtask

   task automatic wait_finish(input int limit);
      int n;
      n = 0;
      while (!fnsh_unrll && n < limit) begin
         next_cycle();
         n++;
      end
      if (!fnsh_unrll) begin
         timeouts++;
         $display("timeout while waiting for the unroll finish");
      end
   endtask

   task automatic enter_loop();
      redirect    = 1'b1;
      redirect_pc = loop_start;
      next_cycle();
      redirect = 1'b0;
      check_port("fetch_pc", fetch_pc, loop_start);
      check_port("loop_strt", 16'(loop_strt), 16'h1);
      next_cycle();
      check_port("lbd_state", 16'(lbd_state), 16'(LBD_DISPATCH));
      dispatching = 1'b1;
      end_passed  = 1'b0;
   endtask

   task automatic pulse_mispredict();
      mis_pred = 1'b1;
      next_cycle();
      mis_pred = 1'b0;
      check_port("lbd_state", 16'(lbd_state), 16'(LBD_IDLE));
      dispatching = 1'b0;
   endtask

   always @(negedge clk) begin : monitor
      logic exp_strt;
      logic exp_fnsh;
      exp_strt = trained && !dispatching && fetch_pc == loop_start;
      exp_fnsh = dispatching && end_passed;
      check_port("loop_strt", 16'(loop_strt), 16'(exp_strt));
      check_port("fnsh_unrll", 16'(fnsh_unrll), 16'(exp_fnsh));
      check_port("inst_valid", 16'(inst_valid), 16'(expected_mask(fetch_pc)));
      if (rst) check_port("fetch_pc", fetch_pc, `RESET_PC);
      if (dispatching && holds_end(fetch_pc)) end_passed = 1'b1;
   end

   initial begin
      #100us;
      $display("simulation watchdog expired");
      $display("Finished with errors");
      $finish;
   end

   initial begin : stimulus
      int n;
      errors      = 0;
      timeouts    = 0;
      trained     = 1'b0;
      dispatching = 1'b0;
      end_passed  = 1'b0;
      rst         = 1'b1;
      redirect    = 1'b0;
      redirect_pc = '0;
      mis_pred    = 1'b0;
      void'($urandom(32'h5152));
      // body length keeps the loop end in slot 3 of an aligned bundle
      body_off   = 11 + 4 * int'($urandom_range(0, 7));
      loop_end   = 16'h0140 + pc_t'($urandom_range(0, 63));
      loop_start = loop_end - pc_t'(body_off);

      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      check_port("fetch_pc", fetch_pc, `RESET_PC);

      // run forward to the branch, then jump back as a taken branch would
      n = 0;
      while (!holds_end(fetch_pc) && n < 100) begin
         next_cycle();
         n++;
      end
      if (!holds_end(fetch_pc)) begin
         timeouts++;
         $display("timeout while fetching toward the loop end");
      end
      redirect    = 1'b1;
      redirect_pc = loop_start;
      next_cycle();
      redirect = 1'b0;
      check_port("lbd_state", 16'(lbd_state), 16'(LBD_TRAIN));

      wait_state(LBD_IDLE, 20);
      check_port("trained end bundle", 16'(holds_end(fetch_pc - 16'd4)), 16'h1);
      trained = 1'b1;

      // an address outside the loop must not start dispatch
      redirect    = 1'b1;
      redirect_pc = loop_end + 16'h0200;
      next_cycle();
      redirect = 1'b0;
      repeat (6) next_cycle();

      enter_loop();
      wait_stall(40);
      check_port("fnsh_unrll", 16'(fnsh_unrll), 16'h1);
      repeat ($urandom_range(1, 6)) next_cycle();
      pulse_mispredict();

      repeat (2) next_cycle();
      enter_loop();
      // jump to the branch so it lands in a random slot
      redirect    = 1'b1;
      redirect_pc = loop_end - pc_t'($urandom_range(0, 3));
      next_cycle();
      redirect = 1'b0;
      wait_finish(20);
      next_cycle();
      pulse_mispredict();
      repeat (4) next_cycle();

      $display("errors %0d timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
